//--- cart_map.f
+incdir+src
src/cart_map_pkg.sv
src/cart_cfg_regs.sv
src/cart_addr_map.sv
src/cart_map.sv
sim/cart_map_props.sv
sim/cart_map_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --assert \
    -f cart_map.f --top-module cart_map_tb \
    -Mdir "$OBJ" -o cart_map_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$OBJ/cart_map_sim" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation run returned an error status"
  exit 1
fi

cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi

exit 0

//--- sim/cart_map_props.sv
`timescale 1ns/10ps
`include "cart_map_defs.svh"

// Decoder properties, bound into every cart_addr_map
module cart_map_props
  import cart_map_pkg::*;
(
  input logic    CLK,
  input logic    rst_n,
  input mapper_e mapper,
  input logic    msu_en,
  input logic    is_saveram,
  input logic    is_writable,
  input logic    msu_enable,
  input logic    cx4_enable
);

  logic [3:0] since_rst;  // Edges since reset, saturating

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      since_rst <= 4'd0;
    end else if (since_rst != 4'hF) begin
      since_rst <= since_rst + 4'd1;
    end
  end

  //////////////////////////////
  // Decode flags
  //////////////////////////////

  a_writable_is_sram: assert property (@(posedge CLK) disable iff (!rst_n)
    is_writable == is_saveram)
    else $error("is_writable differs from is_saveram");

  a_cx4_no_sram: assert property (@(posedge CLK) disable iff (!rst_n)
    (mapper == MAP_CX4) |-> !is_saveram)
    else $error("save RAM decoded under the Cx4 mapper");

  //////////////////////////////
  // Window filters
  //////////////////////////////

  // Filter drains 3 edges after MSU1 is switched off
  a_msu_off: assert property (@(posedge CLK) disable iff (!rst_n)
    (!msu_en && !$past(msu_en, 1) && !$past(msu_en, 2) && !$past(msu_en, 3))
      |-> !msu_enable)
    else $error("msu_enable high while MSU1 is disabled");

  a_filt_reset: assert property (@(posedge CLK) disable iff (!rst_n)
    (since_rst < 4'd6) |-> (!msu_enable && !cx4_enable))
    else $error("window enable high within 6 cycles of reset");

endmodule

bind cart_addr_map cart_map_props i_props (
  .CLK         (CLK),
  .rst_n       (rst_n),
  .mapper      (mapper),
  .msu_en      (msu_en),
  .is_saveram  (is_saveram),
  .is_writable (is_writable),
  .msu_enable  (msu_enable),
  .cx4_enable  (cx4_enable)
);

//--- sim/cart_map_tb.sv
`timescale 1ns/10ps
`include "cart_map_defs.svh"

// Cartridge mapper testbench
// Inputs change on the falling edge
// Outputs compared late in the high phase
module cart_map_tb
  import cart_map_pkg::*;
();

  localparam logic [15:0] SEED = 16'd45157;
  localparam int TEST_CYCLES = 40 + 230 + 240 + 130 + 50;  // Per-test lengths
  localparam int CYCLE_LIMIT = 2 + TEST_CYCLES + 100;       // Reset plus margin
  localparam int HOLD_RISE   = 8;  // Samples before a steady hit must show
  localparam int HOLD_FALL   = 4;  // Samples before a cleared hit must drop

  typedef struct packed {
    logic [`CART_ADDR_W-1:0] rom_addr;
    logic                    is_rom;
    logic                    is_saveram;
    logic                    is_writable;
    logic                    cx4_vect;
    logic                    msu_hit;  // Raw window hits
    logic                    cx4_hit;
  } exp_t;

  logic                    CLK;
  logic                    rst_n;
  logic                    cfg_we;
  cfg_reg_e                cfg_addr;
  logic [`CFG_DATA_W-1:0]  cfg_wdata;
  logic [`CART_ADDR_W-1:0] snes_addr;
  logic                    snes_romsel_n;
  logic [`CART_ADDR_W-1:0] rom_addr;
  logic                    is_rom;
  logic                    is_saveram;
  logic                    is_writable;
  logic                    msu_enable;
  logic                    cx4_enable;
  logic                    cx4_vect_enable;

  // Shadow of the config as written so far
  logic [2:0]              cur_mapper;
  logic [`CART_ADDR_W-1:0] cur_rom_mask;
  logic [`CART_ADDR_W-1:0] cur_sram_mask;
  logic                    cur_msu_en;

  logic [15:0] lfsr;
  logic        chk_on;
  logic        msu_last;   // Last expected raw hits
  logic        cx4_last;
  int          msu_held;   // Samples that hit value has held
  int          cx4_held;
  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_base;  // err_cnt at test start
  int          cycle_cnt;

  cart_map i_dut (.*);

  always #50 CLK = ~CLK;  // 100 ns period

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Expected decode for one bus address
  function automatic exp_t expect_map(input logic [2:0] m, input logic [23:0] rmask,
                                      input logic [23:0] smask, input logic msu,
                                      input logic [23:0] a, input logic romsel_n);
    exp_t        e;
    logic        hirom;
    logic        cx4;
    logic        sram;
    logic [23:0] roff;
    logic [23:0] soff;
    hirom = (m == 3'd0);
    cx4   = (m == 3'd2);  // Spare codes act as LoROM
    if (hirom) begin
      e.is_rom = !romsel_n && (a[22] || a[15]);
      roff     = a & 24'h3FFFFF;
      sram     = !a[22] && a[21] && (a[15:13] == 3'b011);
      soff     = ((a >> 3) & 24'h03E000) | (a & 24'h001FFF);  // 20:16 then 12:0
    end else begin
      e.is_rom = !romsel_n && a[15];
      roff     = ((a >> 1) & 24'h3F8000) | (a & 24'h007FFF);  // A15 dropped
      sram     = (a[22:20] == 3'b111) && (a[22:17] != 6'h3F) && !a[15] && !cx4;
      soff     = ((a >> 1) & 24'h078000) | (a & 24'h007FFF);
    end
    e.rom_addr    = sram ? (`SRAM_BASE + (soff & smask)) : (roff & rmask);
    e.is_saveram  = sram;
    e.is_writable = sram;
    e.cx4_vect    = cx4 && (a[15:5] == 11'h7FF);
    e.msu_hit     = msu && !a[22] && (a[15:0] >= 16'h2000) && (a[15:0] <= 16'h2007);
    e.cx4_hit     = cx4 && !a[22] && (a[15:0] >= 16'h6000) && (a[15:0] <= 16'h7FFF);
    return e;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s (addr %h)", $time, msg, snes_addr);
    err_cnt++;
  endtask

  // One config byte with its shadow update
  task automatic write_cfg(input cfg_reg_e idx, input logic [7:0] data);
    @(negedge CLK);
    cfg_we    = 1'b1;
    cfg_addr  = idx;
    cfg_wdata = data;
    case (idx)
      CFG_MAPPER:     cur_mapper          = data[2:0];
      CFG_ROM_MASK0:  cur_rom_mask[7:0]   = data;
      CFG_ROM_MASK1:  cur_rom_mask[15:8]  = data;
      CFG_ROM_MASK2:  cur_rom_mask[23:16] = data;
      CFG_SRAM_MASK0: cur_sram_mask[7:0]  = data;
      CFG_SRAM_MASK1: cur_sram_mask[15:8] = data;
      CFG_SRAM_MASK2: cur_sram_mask[23:16] = data;
      default:        cur_msu_en          = data[0];
    endcase
    @(negedge CLK);
    cfg_we = 1'b0;
  endtask

  task automatic load_rom_mask();
    write_cfg(CFG_ROM_MASK0, 8'(rand_bits(8)));
    write_cfg(CFG_ROM_MASK1, 8'(rand_bits(8)));
    write_cfg(CFG_ROM_MASK2, 8'(rand_bits(8)));
  endtask

  // Address held for a number of cycles
  task automatic drive_addr(input logic [23:0] a, input logic sel_n, input int cycles);
    @(negedge CLK);
    snes_addr     = a;
    snes_romsel_n = sel_n;
    repeat (cycles - 1) @(negedge CLK);
  endtask

  task automatic start_test();
    test_base = err_cnt;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_base);
  endtask

  //////////////////////////////
  // Compare
  //////////////////////////////

  task automatic compare_outputs();
    exp_t e;
    e = expect_map(cur_mapper, cur_rom_mask, cur_sram_mask, cur_msu_en,
                   snes_addr, snes_romsel_n);
    check_cnt++;
    assert (rom_addr === e.rom_addr)
      else report_mismatch($sformatf("rom_addr got %h expected %h", rom_addr, e.rom_addr));
    assert (is_rom === e.is_rom)
      else report_mismatch($sformatf("is_rom got %b expected %b", is_rom, e.is_rom));
    assert (is_saveram === e.is_saveram)
      else report_mismatch($sformatf("is_saveram got %b expected %b",
                                     is_saveram, e.is_saveram));
    assert (is_writable === e.is_writable)
      else report_mismatch($sformatf("is_writable got %b expected %b",
                                     is_writable, e.is_writable));
    assert (cx4_vect_enable === e.cx4_vect)
      else report_mismatch($sformatf("cx4_vect_enable got %b expected %b",
                                     cx4_vect_enable, e.cx4_vect));
    // Filtered enables only once the hit has settled
    if (e.msu_hit == msu_last) begin
      msu_held++;
    end else begin
      msu_last = e.msu_hit;
      msu_held = 1;
    end
    if (e.cx4_hit == cx4_last) begin
      cx4_held++;
    end else begin
      cx4_last = e.cx4_hit;
      cx4_held = 1;
    end
    if (msu_held >= (msu_last ? HOLD_RISE : HOLD_FALL)) begin
      assert (msu_enable === msu_last)
        else report_mismatch($sformatf("msu_enable got %b expected %b", msu_enable, msu_last));
    end
    if (cx4_held >= (cx4_last ? HOLD_RISE : HOLD_FALL)) begin
      assert (cx4_enable === cx4_last)
        else report_mismatch($sformatf("cx4_enable got %b expected %b", cx4_enable, cx4_last));
    end
  endtask

  always @(posedge CLK) begin
    #40;  // Well clear of both edges
    if (chk_on) begin
      compare_outputs();
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Tests
  //////////////////////////////

  initial begin
    logic [23:0] a;
    int          i;
    CLK           = 1'b0;
    rst_n         = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = CFG_MAPPER;
    cfg_wdata     = '0;
    snes_addr     = '0;
    snes_romsel_n = 1'b1;
    cur_mapper    = 3'd1;          // LoROM after reset
    cur_rom_mask  = 24'hFFFFFF;
    cur_sram_mask = 24'h000000;
    cur_msu_en    = 1'b0;
    lfsr          = SEED;
    chk_on        = 1'b0;
    msu_last      = 1'b0;
    cx4_last      = 1'b0;
    msu_held      = 0;
    cx4_held      = 0;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    cycle_cnt     = 0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    rst_n  = 1'b1;
    chk_on = 1'b1;

    // Reset defaults of LoROM with the full ROM mask and save RAM at 0
    start_test();
    drive_addr(24'hFFFFFF, 1'b0, 10);  // Every ROM offset bit set
    drive_addr(24'h701234, 1'b0, 10);
    drive_addr(24'h002003, 1'b0, 10);  // MSU1 still off
    drive_addr(24'h006000, 1'b0, 10);
    finish_test("reset_defaults");

    start_test();
    write_cfg(CFG_MAPPER, 8'h01);
    for (i = 0; i < 200; i++) begin
      if (i % 50 == 0) load_rom_mask();
      drive_addr(24'(rand_bits(24)), 1'(rand_bits(1)), 1);
    end
    finish_test("lorom_random");

    start_test();
    write_cfg(CFG_MAPPER, 8'h00);
    write_cfg(CFG_SRAM_MASK0, 8'(rand_bits(8)));
    write_cfg(CFG_SRAM_MASK1, 8'(rand_bits(8)));
    write_cfg(CFG_SRAM_MASK2, 8'(rand_bits(8)));
    for (i = 0; i < 200; i++) begin
      if (i % 50 == 0) load_rom_mask();
      a = 24'(rand_bits(24));
      if (rand_bits(1) != 0) begin
        a[22:21] = 2'b01;     // Banks 20-3F/A0-BF
        a[15:13] = 3'b011;    // 6000-7FFF
      end
      drive_addr(a, 1'(rand_bits(1)), 1);
    end
    finish_test("hirom_random");

    start_test();
    write_cfg(CFG_MAPPER, 8'h02);
    for (i = 0; i < 100; i++) begin
      a = 24'(rand_bits(24));
      case (2'(rand_bits(2)))
        2'd0: begin
          a[22:20] = 3'b111;  // Where LoROM save RAM would be
          a[15]    = 1'b0;
        end
        2'd1: a[15:5] = 11'h7FF;  // Vector page
        default: ;
      endcase
      drive_addr(a, 1'(rand_bits(1)), 1);
    end
    drive_addr({8'h00, 3'b011, 13'(rand_bits(13))}, 1'b0, 10);
    drive_addr(24'h008000, 1'b0, 6);
    drive_addr(24'h406100, 1'b0, 10);  // Bank 40 is outside the window
    finish_test("cx4_window");

    start_test();
    write_cfg(CFG_MAPPER, 8'h01);
    a = {8'h00, 13'h0400, 3'(rand_bits(3))};
    drive_addr(a, 1'b0, 10);
    write_cfg(CFG_FEATURES, 8'h01);
    drive_addr(a, 1'b0, 10);
    drive_addr(a | 24'h400000, 1'b0, 10);
    write_cfg(CFG_FEATURES, 8'h00);
    drive_addr(a, 1'b0, 10);
    finish_test("msu_window");

    @(negedge CLK);  // Last sample
    $display("done: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- src/cart_addr_map.sv
`timescale 1ns/10ps
`include "cart_map_defs.svh"

// Cartridge address decode
// Flat address and flags are combinational off the bus
// The two register window enables are filtered
module cart_addr_map
  import cart_map_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst_n,
  input  mapper_e                 mapper,
  input  logic [`CART_ADDR_W-1:0] rom_mask,
  input  logic [`CART_ADDR_W-1:0] sram_mask,
  input  logic                    msu_en,
  input  logic [`CART_ADDR_W-1:0] snes_addr,      // Console bus address
  input  logic                    snes_romsel_n,  // ROM select, low active
  output logic [`CART_ADDR_W-1:0] rom_addr,       // Flat memory address
  output logic                    is_rom,
  output logic                    is_saveram,
  output logic                    is_writable,
  output logic                    msu_enable,     // Filtered MSU1 window
  output logic                    cx4_enable,     // Filtered Cx4 window
  output logic                    cx4_vect_enable
);

  localparam int N_WIN   = 2;  // Filtered windows
  localparam int WIN_MSU = 0;
  localparam int WIN_CX4 = 1;

  logic                    map_hirom;  // HiROM shape
  logic                    map_cx4;    // Cx4, LoROM shape
  logic                    lo_rom;
  logic                    hi_rom;
  logic                    lo_sram;
  logic                    hi_sram;
  logic [`CART_ADDR_W-1:0] lo_rom_off;
  logic [`CART_ADDR_W-1:0] hi_rom_off;
  logic [`CART_ADDR_W-1:0] lo_sram_off;
  logic [`CART_ADDR_W-1:0] hi_sram_off;
  logic [`CART_ADDR_W-1:0] rom_off;
  logic [`CART_ADDR_W-1:0] sram_off;
  logic [N_WIN-1:0]        win_hit;  // Raw window hits
  logic [`WIN_FILT_DEPTH-1:0] win_hist [N_WIN];

  //////////////////////////////
  // Mapper select
  //////////////////////////////

  // Unknown codes take the LoROM path
  always_comb begin
    map_hirom = 1'b0;
    map_cx4   = 1'b0;
    case (mapper)
      MAP_HIROM: map_hirom = 1'b1;
      MAP_CX4:   map_cx4   = 1'b1;
      default:   map_hirom = 1'b0;  // LoROM and spare codes
    endcase
  end

  //////////////////////////////
  // ROM decode
  //////////////////////////////

  // LoROM: upper half of each bank, A15 squeezed out
  assign lo_rom     = snes_addr[15] & ~snes_romsel_n;
  assign lo_rom_off = {2'b00, snes_addr[22:16], snes_addr[14:0]};

  // HiROM: whole bank in 40-7D/C0-FF, upper half below
  assign hi_rom     = ~snes_romsel_n & (snes_addr[22] | snes_addr[15]);
  assign hi_rom_off = {2'b00, snes_addr[21:0]};

  // Mirror down to the loaded image size
  assign rom_off = (map_hirom ? hi_rom_off : lo_rom_off) & rom_mask;

  //////////////////////////////
  // Save RAM decode
  //////////////////////////////

  // LoROM: banks 70-7D/F0-FD, lower half only
  assign lo_sram = (&snes_addr[22:20])
                 & ~(&snes_addr[22:17])  // Keeps 7E/7F WRAM out
                 & ~snes_addr[15];
  assign lo_sram_off = {5'd0, snes_addr[19:16], snes_addr[14:0]};

  // HiROM: 6000-7FFF in banks 20-3F/A0-BF
  assign hi_sram = ~snes_addr[22] & snes_addr[21]
                 & (snes_addr[15:13] == 3'b011);
  assign hi_sram_off = {6'd0, snes_addr[20:16], snes_addr[12:0]};

  assign sram_off = (map_hirom ? hi_sram_off : lo_sram_off) & sram_mask;

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign is_rom = map_hirom ? hi_rom : lo_rom;

  // Cx4 boards carry no save RAM
  assign is_saveram = map_hirom ? hi_sram : (lo_sram & ~map_cx4);

  assign is_writable = is_saveram;  // Save RAM is the only writable area

  // Save RAM placed above the ROM image
  assign rom_addr = is_saveram ? (`SRAM_BASE + sram_off) : rom_off;

  // Cx4 vector page FFE0-FFFF
  assign cx4_vect_enable = map_cx4 & (&snes_addr[15:5]);

  //////////////////////////////
  // Window filters
  //////////////////////////////

  // MSU1 regs at 2000-2007, banks 00-3F/80-BF
  assign win_hit[WIN_MSU] = msu_en & ~snes_addr[22]
                          & (snes_addr[15:3] == 13'h0400);  // 2000 >> 3

  // Cx4 regs at 6000-7FFF, same banks
  assign win_hit[WIN_CX4] = map_cx4 & ~snes_addr[22]
                          & (snes_addr[15:13] == 3'b011);

  // Shift history, newest sample at bit 0
  // Skipping the newest bits rides out address settling glitches
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_WIN; i++) begin
        win_hist[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_WIN; i++) begin
        win_hist[i] <= {win_hist[i][`WIN_FILT_DEPTH-2:0], win_hit[i]};
      end
    end
  end

  // Steady hit: up on 6th edge, down 3 edges after it ends
  assign msu_enable = &win_hist[WIN_MSU][`WIN_FILT_DEPTH-1:`WIN_FILT_SKIP];
  assign cx4_enable = &win_hist[WIN_CX4][`WIN_FILT_DEPTH-1:`WIN_FILT_SKIP];

endmodule

//--- src/cart_cfg_regs.sv
`timescale 1ns/10ps
`include "cart_map_defs.svh"

// Config block loaded by the microcontroller
// One byte per strobe, no acknowledge
module cart_cfg_regs
  import cart_map_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    cfg_we,     // Write strobe
  input  cfg_reg_e                cfg_addr,   // Register index
  input  logic [`CFG_DATA_W-1:0]  cfg_wdata,  // Write byte
  output mapper_e                 mapper,
  output logic [`CART_ADDR_W-1:0] rom_mask,
  output logic [`CART_ADDR_W-1:0] sram_mask,
  output logic                    msu_en
);

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Written values reach the decoder the cycle after the edge
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mapper    <= MAP_LOROM;       // Safe default shape
      rom_mask  <= `ROM_MASK_RST;
      sram_mask <= `SRAM_MASK_RST;
      msu_en    <= 1'b0;            // MSU1 off until enabled
    end else if (cfg_we) begin
      case (cfg_addr)
        CFG_MAPPER: begin
          mapper <= mapper_e'(cfg_wdata[2:0]);  // Upper bits dropped
        end
        // ROM mask, assembled low byte first
        CFG_ROM_MASK0: begin
          rom_mask[7:0] <= cfg_wdata;
        end
        CFG_ROM_MASK1: begin
          rom_mask[15:8] <= cfg_wdata;
        end
        CFG_ROM_MASK2: begin
          rom_mask[23:16] <= cfg_wdata;
        end
        // Save RAM mask, same layout
        CFG_SRAM_MASK0: begin
          sram_mask[7:0] <= cfg_wdata;
        end
        CFG_SRAM_MASK1: begin
          sram_mask[15:8] <= cfg_wdata;
        end
        CFG_SRAM_MASK2: begin
          sram_mask[23:16] <= cfg_wdata;
        end
        CFG_FEATURES: begin
          msu_en <= cfg_wdata[0];  // Other feature bits reserved
        end
        // All eight indices are named above
      endcase
    end
  end

endmodule

//--- src/cart_map.sv
`timescale 1ns/10ps
`include "cart_map_defs.svh"

// Cartridge mapper top
// Config registers feeding the address decoder
module cart_map
  import cart_map_pkg::*;
(
  input  logic                    CLK,
  input  logic                    rst_n,
  // Microcontroller config port
  input  logic                    cfg_we,
  input  cfg_reg_e                cfg_addr,
  input  logic [`CFG_DATA_W-1:0]  cfg_wdata,
  // Console bus
  input  logic [`CART_ADDR_W-1:0] snes_addr,
  input  logic                    snes_romsel_n,
  // Decode results
  output logic [`CART_ADDR_W-1:0] rom_addr,
  output logic                    is_rom,
  output logic                    is_saveram,
  output logic                    is_writable,
  output logic                    msu_enable,
  output logic                    cx4_enable,
  output logic                    cx4_vect_enable
);

  //////////////////////////////
  // Config to decoder
  //////////////////////////////

  mapper_e                 mapper;
  logic [`CART_ADDR_W-1:0] rom_mask;
  logic [`CART_ADDR_W-1:0] sram_mask;
  logic                    msu_en;

  cart_cfg_regs i_cfg (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .mapper    (mapper),
    .rom_mask  (rom_mask),
    .sram_mask (sram_mask),
    .msu_en    (msu_en)
  );

  cart_addr_map i_map (
    .CLK             (CLK),
    .rst_n           (rst_n),
    .mapper          (mapper),
    .rom_mask        (rom_mask),
    .sram_mask       (sram_mask),
    .msu_en          (msu_en),
    .snes_addr       (snes_addr),
    .snes_romsel_n   (snes_romsel_n),
    .rom_addr        (rom_addr),
    .is_rom          (is_rom),
    .is_saveram      (is_saveram),
    .is_writable     (is_writable),
    .msu_enable      (msu_enable),
    .cx4_enable      (cx4_enable),
    .cx4_vect_enable (cx4_vect_enable)
  );

endmodule

//--- src/cart_map_defs.svh
`ifndef CART_MAP_DEFS_SVH
`define CART_MAP_DEFS_SVH

//////////////////////////////
// Bus widths
//////////////////////////////

// Console bus and flat memory address
`define CART_ADDR_W 24

// Microcontroller config port
`define CFG_DATA_W 8
`define CFG_ADDR_W 3

//////////////////////////////
// Config reset values
//////////////////////////////

`define ROM_MASK_RST  {`CART_ADDR_W{1'b1}}  // Full ROM visible
`define SRAM_MASK_RST {`CART_ADDR_W{1'b0}}  // Save RAM folds to offset 0

// Save RAM sits above the ROM image in memory
`define SRAM_BASE 24'hE00000

//////////////////////////////
// Window enable filter
//////////////////////////////

`define WIN_FILT_DEPTH 6  // History length, newest at bit 0
`define WIN_FILT_SKIP  2  // Newest samples left out of the AND

`endif

//--- src/cart_map_pkg.sv
`include "cart_map_defs.svh"

package cart_map_pkg;

  //////////////////////////////
  // Mapper kind
  //////////////////////////////

  // Codes as detected by the microcontroller
  // Unlisted codes fall back to LoROM in the decoder
  typedef enum logic [2:0] {
    MAP_HIROM = 3'd0,
    MAP_LOROM = 3'd1,
    MAP_CX4   = 3'd2   // LoROM shape, no save RAM
  } mapper_e;

  //////////////////////////////
  // Config register index
  //////////////////////////////

  typedef enum logic [`CFG_ADDR_W-1:0] {
    CFG_MAPPER     = 3'd0,  // Low 3 bits only
    CFG_ROM_MASK0  = 3'd1,  // ROM mask, low byte
    CFG_ROM_MASK1  = 3'd2,
    CFG_ROM_MASK2  = 3'd3,  // ROM mask, high byte
    CFG_SRAM_MASK0 = 3'd4,  // Save RAM mask, low byte
    CFG_SRAM_MASK1 = 3'd5,
    CFG_SRAM_MASK2 = 3'd6,  // Save RAM mask, high byte
    CFG_FEATURES   = 3'd7   // Bit 0 is MSU1 enable
  } cfg_reg_e;

endpackage
